//--- logic/imul_msg_pkg.sv
package imul_msg_pkg;

  // ----------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------

  // Operand and result width, one machine word
  localparam int imul_data_w = 32;

  // Request carries both operands side by side
  localparam int imul_req_w = 2 * imul_data_w;

  // Iteration counter has to hold 0 through 32
  localparam int imul_count_w = 6;

  // ----------------------------------------------------------
  // Message formats
  // ----------------------------------------------------------

  // Request layout
  //   [63:32] operand a
  //   [31:0]  operand b
  typedef struct packed {
    logic [imul_data_w-1:0] a;
    logic [imul_data_w-1:0] b;
  } imul_req_t;

  // Response is the low word of the product
  // Same bits for signed and unsigned operands
  typedef logic [imul_data_w-1:0] imul_resp_t;

endpackage

//--- logic/imul_ctrl_pkg.sv
package imul_ctrl_pkg;

  // FSM states of the sequencer
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } imul_state_t;

  // Operand a register input
  typedef enum logic {
    A_LOAD  = 1'b0,
    A_SHIFT = 1'b1
  } imul_a_sel_t;

  // Operand b register input
  typedef enum logic {
    B_LOAD  = 1'b0,
    B_SHIFT = 1'b1
  } imul_b_sel_t;

  // Result register input
  typedef enum logic {
    RES_CLEAR = 1'b0,
    RES_ADD   = 1'b1
  } imul_res_sel_t;

  // One iteration per bit of b at most
  localparam int imul_max_iter = 32;

endpackage

//--- logic/imul_msg_queue.sv
`timescale 1ns/1ps

module imul_msg_queue
  import imul_msg_pkg::*;
#(
  parameter type msg_t = imul_resp_t
)
(
  input  logic clk,
  input  logic reset,
  input  logic enq_val,
  output logic enq_rdy,
  input  msg_t enq_msg,
  output logic deq_val,
  input  logic deq_rdy,
  output msg_t deq_msg
);

  // Two slots, one pointer bit each side
  msg_t       buf_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;

  logic enq_fire;
  logic deq_fire;

  // Ready only looks at the fill level, never at enq_val
  assign enq_rdy  = (count_q < 2'd2);
  assign deq_val  = (count_q != 2'd0);
  assign deq_msg  = buf_q[rd_ptr_q];

  assign enq_fire = enq_val && enq_rdy;
  assign deq_fire = deq_val && deq_rdy;

  // Storage, written on every accepted item
  always_ff @(posedge clk)
  begin
    if (enq_fire)
    begin
      buf_q[wr_ptr_q] <= enq_msg;
    end
  end

  // Pointers and fill count
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end
    else
    begin
      if (enq_fire)
        wr_ptr_q <= ~wr_ptr_q;
      if (deq_fire)
        rd_ptr_q <= ~rd_ptr_q;
      // Simultaneous enq and deq leaves the level unchanged
      case ({enq_fire, deq_fire})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------

  // Head item held while the consumer stalls
  assert property (@(posedge clk) disable iff (reset)
    deq_val && !deq_rdy |=> deq_val && $stable(deq_msg));

  // Producer keeps its item offered while the queue is full
  assert property (@(posedge clk) disable iff (reset)
    enq_val && !enq_rdy |=> enq_val && $stable(enq_msg));

endmodule

//--- logic/imul_dpath.sv
`timescale 1ns/1ps

module imul_dpath
  import imul_msg_pkg::*;
  import imul_ctrl_pkg::*;
(
  input  logic          clk,
  input  imul_req_t     req_msg,
  input  imul_a_sel_t   a_sel,
  input  imul_b_sel_t   b_sel,
  input  imul_res_sel_t res_sel,
  input  logic          a_en,
  input  logic          b_en,
  input  logic          res_en,
  input  logic          count_clr,
  input  logic          count_en,
  output logic          b_zero,
  output logic          count_done,
  output imul_resp_t    result
);

  // ----------------------------------------------------------
  // Operand unpacking
  // ----------------------------------------------------------

  // a sits in the upper half, b in the lower half
  logic [imul_data_w-1:0] req_a;
  logic [imul_data_w-1:0] req_b;

  assign req_a = req_msg[imul_req_w-1 -: imul_data_w];
  assign req_b = req_msg[imul_data_w-1:0];

  // ----------------------------------------------------------
  // Registers and next values
  // ----------------------------------------------------------

  logic [imul_data_w-1:0]  a_q;
  logic [imul_data_w-1:0]  b_q;
  logic [imul_data_w-1:0]  res_q;
  logic [imul_count_w-1:0] count_q;

  logic [imul_data_w-1:0]  a_d;
  logic [imul_data_w-1:0]  b_d;
  logic [imul_data_w-1:0]  res_d;
  logic [imul_data_w-1:0]  addend;

  // Partial product for this step
  assign addend = b_q[0] ? a_q : '0;

  // a moves one place up per step
  assign a_d = (a_sel == A_LOAD) ? req_a : (a_q << 1);

  // b moves one place down so bit 0 is always the current bit
  assign b_d = (b_sel == B_LOAD) ? req_b : (b_q >> 1);

  // Carry out of bit 31 is dropped, only the low word is kept
  assign res_d = (res_sel == RES_CLEAR) ? '0 : (res_q + addend);

  always_ff @(posedge clk)
  begin
    if (a_en)
      a_q <= a_d;
    if (b_en)
      b_q <= b_d;
    if (res_en)
      res_q <= res_d;
  end

  // Step counter, cleared with each new request
  always_ff @(posedge clk)
  begin
    if (count_clr)
      count_q <= '0;
    else if (count_en)
      count_q <= count_q + imul_count_w'(1);
  end

  // ----------------------------------------------------------
  // Status back to the FSM
  // ----------------------------------------------------------

  // No set bits left means nothing more to add
  assign b_zero     = (b_q == '0);
  assign count_done = (count_q == imul_count_w'(imul_max_iter));
  assign result     = res_q;

  // FSM has to stop stepping once the limit is reached
  assert property (@(posedge clk)
    !$isunknown(count_q) |-> count_q <= imul_count_w'(imul_max_iter));

endmodule

//--- logic/imul_ctrl.sv
`timescale 1ns/1ps

module imul_ctrl
  import imul_msg_pkg::*;
  import imul_ctrl_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          deq_val,
  output logic          deq_rdy,
  output logic          resp_enq_val,
  input  logic          resp_enq_rdy,
  input  logic          b_zero,
  input  logic          count_done,
  output imul_a_sel_t   a_sel,
  output imul_b_sel_t   b_sel,
  output imul_res_sel_t res_sel,
  output logic          a_en,
  output logic          b_en,
  output logic          res_en,
  output logic          count_clr,
  output logic          count_en
);

  imul_state_t state_q;
  imul_state_t state_d;

  logic deq_fire;
  logic calc_end;

  // Handshakes depend on state only
  assign deq_rdy      = (state_q == IDLE);
  assign resp_enq_val = (state_q == DONE);

  assign deq_fire = deq_val && deq_rdy;

  // Leave CALC when no bits are left or the step limit is hit
  assign calc_end = b_zero || count_done;

  // ----------------------------------------------------------
  // State register
  // ----------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // ----------------------------------------------------------
  // Next state and datapath controls
  // ----------------------------------------------------------

  always_comb
  begin
    state_d   = state_q;
    a_sel     = A_LOAD;
    b_sel     = B_LOAD;
    res_sel   = RES_CLEAR;
    a_en      = 1'b0;
    b_en      = 1'b0;
    res_en    = 1'b0;
    count_clr = 1'b0;
    count_en  = 1'b0;

    case (state_q)
      IDLE:
      begin
        // Load operands and clear result and counter on accept
        a_en      = deq_fire;
        b_en      = deq_fire;
        res_en    = deq_fire;
        count_clr = deq_fire;
        if (deq_fire)
          state_d = CALC;
      end

      CALC:
      begin
        if (calc_end)
        begin
          state_d = DONE;
        end
        else
        begin
          // One shift-and-add step
          a_sel    = A_SHIFT;
          b_sel    = B_SHIFT;
          res_sel  = RES_ADD;
          a_en     = 1'b1;
          b_en     = 1'b1;
          res_en   = 1'b1;
          count_en = 1'b1;
        end
      end

      DONE:
      begin
        // Result held until the response queue takes it
        if (resp_enq_rdy)
          state_d = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

  // A result is offered only once every set bit of b has been added
  assert property (@(posedge clk) disable iff (reset)
    $rose(resp_enq_val) |-> $past(b_zero));

endmodule

//--- logic/imul_unit.sv
`timescale 1ns/1ps

module imul_unit
  import imul_msg_pkg::*;
  import imul_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       req_val,
  output logic       req_rdy,
  input  imul_req_t  req_msg,
  output logic       resp_val,
  input  logic       resp_rdy,
  output imul_resp_t resp_msg
);

  // Request queue to FSM and datapath
  logic          deq_val;
  logic          deq_rdy;
  imul_req_t     deq_msg;

  // FSM and datapath to response queue
  logic          resp_enq_val;
  logic          resp_enq_rdy;
  imul_resp_t    result;

  // FSM to datapath
  imul_a_sel_t   a_sel;
  imul_b_sel_t   b_sel;
  imul_res_sel_t res_sel;
  logic          a_en;
  logic          b_en;
  logic          res_en;
  logic          count_clr;
  logic          count_en;

  // Datapath status
  logic          b_zero;
  logic          count_done;

  // ----------------------------------------------------------
  // Input buffering
  // ----------------------------------------------------------

  imul_msg_queue #(
    .msg_t (imul_req_t)
  ) u_req_queue (
    .clk     (clk),
    .reset   (reset),
    .enq_val (req_val),
    .enq_rdy (req_rdy),
    .enq_msg (req_msg),
    .deq_val (deq_val),
    .deq_rdy (deq_rdy),
    .deq_msg (deq_msg)
  );

  // ----------------------------------------------------------
  // Multiplier core
  // ----------------------------------------------------------

  imul_ctrl u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .deq_val      (deq_val),
    .deq_rdy      (deq_rdy),
    .resp_enq_val (resp_enq_val),
    .resp_enq_rdy (resp_enq_rdy),
    .b_zero       (b_zero),
    .count_done   (count_done),
    .a_sel        (a_sel),
    .b_sel        (b_sel),
    .res_sel      (res_sel),
    .a_en         (a_en),
    .b_en         (b_en),
    .res_en       (res_en),
    .count_clr    (count_clr),
    .count_en     (count_en)
  );

  imul_dpath u_dpath (
    .clk        (clk),
    .req_msg    (deq_msg),
    .a_sel      (a_sel),
    .b_sel      (b_sel),
    .res_sel    (res_sel),
    .a_en       (a_en),
    .b_en       (b_en),
    .res_en     (res_en),
    .count_clr  (count_clr),
    .count_en   (count_en),
    .b_zero     (b_zero),
    .count_done (count_done),
    .result     (result)
  );

  // Output buffering, absorbs sink stalls
  imul_msg_queue #(
    .msg_t (imul_resp_t)
  ) u_resp_queue (
    .clk     (clk),
    .reset   (reset),
    .enq_val (resp_enq_val),
    .enq_rdy (resp_enq_rdy),
    .enq_msg (result),
    .deq_val (resp_val),
    .deq_rdy (resp_rdy),
    .deq_msg (resp_msg)
  );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
  parameter int half_period_ns = 10
)
(
  output logic clk
);

  // Free running, first rising edge at one half period
  initial
  begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

endmodule

//--- tb/imul_unit_tb.sv
`timescale 1ns/1ps

module imul_unit_tb
  import imul_msg_pkg::*;
();

  localparam int n_fixed     = 16;
  localparam int n_rand      = 8;
  localparam int n_rows      = n_fixed + n_rand;
  // Table runs once with no delays, then once with random delays
  localparam int n_items     = 2 * n_rows;
  localparam int max_delay   = 15;
  localparam int max_lat     = 36;
  localparam int cycle_limit = n_items * (max_lat + 2 * max_delay) + 200;

  typedef struct packed {
    logic [imul_data_w-1:0] a;
    logic [imul_data_w-1:0] b;
    logic [imul_data_w-1:0] p;
  } row_t;

  logic       clk;
  logic       reset;
  logic       req_val;
  logic       req_rdy;
  imul_req_t  req_msg;
  logic       resp_val;
  logic       resp_rdy;
  imul_resp_t resp_msg;

  row_t        rows [$];
  int          errors;
  int          full_stalls;
  int          cycles;
  logic [31:0] gen_state;
  logic [31:0] src_state;
  logic [31:0] snk_state;

  tb_clock_gen u_clock_gen (.clk(clk));

  imul_unit u_imul_unit (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      errors++;
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic add_row(input logic [31:0] a, input logic [31:0] b, input logic [31:0] p);
    row_t r;
    r.a = a;
    r.b = b;
    r.p = p;
    rows.push_back(r);
  endtask

  // Low product word matches for signed and unsigned operands
  task automatic add_random_rows();
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < n_rand; i++)
    begin
      gen_state = lcg_next(gen_state);
      a = gen_state;
      gen_state = lcg_next(gen_state);
      // Random right shift shortens b, so latency varies
      b = gen_state >> gen_state[27:23];
      add_row(a, b, a * b);
    end
  endtask

  // ----------------------------------------------------------
  // Source and sink
  // ----------------------------------------------------------

  task automatic run_source();
    int   gap;
    logic fire;
    for (int i = 0; i < n_items; i++)
    begin
      gap = 0;
      if (i >= n_rows)
      begin
        src_state = lcg_next(src_state);
        gap = int'(src_state[31:28]) % 4;
      end
      req_val = 1'b0;
      repeat (gap)
      begin
        @(posedge clk);
        #1;
      end
      req_val   = 1'b1;
      req_msg.a = rows[i % n_rows].a;
      req_msg.b = rows[i % n_rows].b;
      fire = 1'b0;
      // Transfer happens on the edge after a high req_rdy
      while (!fire)
      begin
        @(negedge clk);
        fire = req_rdy;
        @(posedge clk);
        #1;
      end
    end
    req_val = 1'b0;
  endtask

  task automatic run_sink();
    int   stall;
    logic fire;
    for (int i = 0; i < n_items; i++)
    begin
      if (i >= n_rows)
      begin
        snk_state = lcg_next(snk_state);
        stall = int'(snk_state[31:28]);
        resp_rdy = 1'b0;
        repeat (stall)
        begin
          @(posedge clk);
          #1;
        end
      end
      resp_rdy = 1'b1;
      fire = 1'b0;
      while (!fire)
      begin
        @(negedge clk);
        fire = resp_val;
        if (fire)
          check("resp_msg", rows[i % n_rows].p, resp_msg);
        @(posedge clk);
        #1;
      end
    end
  endtask

  // Full pipeline seen as req_rdy low during a sink stall
  always @(negedge clk)
  begin
    if (!reset && !resp_rdy && !req_rdy)
      full_stalls++;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycle_limit)
    begin
      $display("Run timed out after %0d cycles, a response never arrived", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial
  begin
    reset       = 1'b1;
    req_val     = 1'b0;
    req_msg     = '0;
    resp_rdy    = 1'b0;
    errors      = 0;
    full_stalls = 0;
    cycles      = 0;
    gen_state   = 32'd29;

    // Sign combinations, zero, one and minus one
    add_row(32'h00000003, 32'h00000005, 32'h0000000f);
    add_row(32'hfffffffd, 32'h00000005, 32'hfffffff1);
    add_row(32'h00000003, 32'hfffffffb, 32'hfffffff1);
    add_row(32'hfffffffd, 32'hfffffffb, 32'h0000000f);
    add_row(32'h00000000, 32'h000004d2, 32'h00000000);
    add_row(32'h000004d2, 32'h00000000, 32'h00000000);
    add_row(32'h00000001, 32'h7fffffff, 32'h7fffffff);
    add_row(32'hffffffff, 32'h00000007, 32'hfffffff9);
    add_row(32'h00000007, 32'hffffffff, 32'hfffffff9);
    add_row(32'hffffffff, 32'hffffffff, 32'h00000001);
    // Large, sparse and dense operands, b top bit set
    add_row(32'h00010000, 32'h00010000, 32'h00000000);
    add_row(32'h12345679, 32'h80000000, 32'h80000000);
    add_row(32'h0000ffff, 32'h0000ffff, 32'hfffe0001);
    add_row(32'h80000001, 32'h00010001, 32'h80010001);
    add_row(32'hdeadbeef, 32'h00000002, 32'hbd5b7dde);
    add_row(32'h0000b505, 32'h0000b505, 32'h80001219);
    add_random_rows();
    src_state = lcg_next(gen_state);
    snk_state = lcg_next(src_state);

    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle unit after reset
    repeat (10)
    begin
      @(negedge clk);
      check("req_rdy", 32'd1, 32'(req_rdy));
      check("resp_val", 32'd0, 32'(resp_val));
    end
    @(posedge clk);
    #1;

    fork
      run_source();
      run_sink();
    join

    // No response beyond the table
    resp_rdy = 1'b1;
    repeat (40)
    begin
      @(negedge clk);
      check("resp_val", 32'd0, 32'(resp_val));
    end

    if (full_stalls == 0)
    begin
      errors++;
      $display("req_rdy never fell while resp_rdy was held low");
    end
    $display("errors %0d, full stalls %0d", errors, full_stalls);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- imul_unit.f
logic/imul_msg_pkg.sv
logic/imul_ctrl_pkg.sv
logic/imul_msg_queue.sv
logic/imul_dpath.sv
logic/imul_ctrl.sv
logic/imul_unit.sv
tb/tb_clock_gen.sv
tb/imul_unit_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= imul_unit_tb
RTL_TOP    ?= imul_unit
FILELIST   ?= imul_unit.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall
PASS_MSG   ?= TEST OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
